/* gb_frontend.f */
source/frontend_regs_pkg.sv
source/video_pkg.sv
source/frontend_control.sv
source/video_sync_shaper.sv
source/pixel_colour_stage.sv
source/gb_frontend.sv
verification/frontend_properties.sv
verification/frontend_checker.sv
verification/tb_gb_frontend.sv

/* verification/tb_gb_frontend.sv */
`timescale 1ns/1ps

module tb_gb_frontend import frontend_regs_pkg::*, video_pkg::*;;

    localparam int unsigned RESET_HOLD_CYCLES = 20;
    localparam int unsigned FF_TAP_CYCLES     = 16;
    localparam int unsigned HS_DELAY          = 7;

    // sync columns are hs, vs, hblank, vblank
    localparam logic [3:0] ACTIVE  = 4'b0000;
    localparam logic [3:0] VBLANK  = 4'b0001;
    localparam logic [3:0] VS_EDGE = 4'b0101;
    localparam logic [3:0] HBLANK  = 4'b0010;
    localparam logic [3:0] HS_EDGE = 4'b1010;
    // frame start, hs and vs rise together
    localparam logic [3:0] HV_EDGE = 4'b1111;

    typedef enum logic [1:0] {OP_IDLE, OP_WR, OP_RD} op_t;

    typedef struct packed {
        op_t          op;
        bridge_addr_t addr;
        bridge_data_t data;
        logic         key;
        logic [3:0]   sync;
        logic [7:0]   hold;
    } step_t;

    logic          clk_sys = 1'b0;
    logic          arst_n;
    bridge_addr_t  bridge_addr;
    logic          bridge_wr;
    bridge_data_t  bridge_wr_data;
    logic          bridge_rd;
    cont_key_t     cont1_key;
    lcd_video_t    lcd_in;
    bridge_data_t  bridge_rd_data;
    logic          core_reset_n;
    logic          fast_forward;
    scaler_video_t video_out;
    int            error_count;
    int            check_count;
    int            timeout_cycles = 0;
    logic [31:0]   rng;
    step_t         steps[$];

    always #20 clk_sys = ~clk_sys;

    gb_frontend #(
        .RESET_HOLD_CYCLES (RESET_HOLD_CYCLES),
        .FF_TAP_CYCLES     (FF_TAP_CYCLES),
        .HS_DELAY          (HS_DELAY)
    ) dut_i (.*);

    frontend_checker #(
        .RESET_HOLD_CYCLES (RESET_HOLD_CYCLES),
        .FF_TAP_CYCLES     (FF_TAP_CYCLES),
        .HS_DELAY          (HS_DELAY)
    ) checker_i (.*);

    bind gb_frontend frontend_properties props_i (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function void add_step(op_t op, bridge_addr_t addr, bridge_data_t data, logic key,
                           logic [3:0] sync, logic [7:0] hold);
        steps.push_back('{op, addr, data, key, sync, hold});
    endfunction

    // strobes only in the first cycle, key and sync held for the whole step
    task automatic apply_step(input step_t s);
        for (int i = 0; i < s.hold; i++) begin
            @(posedge clk_sys);
            #2;
            bridge_wr      = (i == 0) && (s.op == OP_WR);
            bridge_rd      = (i == 0) && (s.op == OP_RD);
            bridge_addr    = s.addr;
            bridge_wr_data = s.data;
            cont1_key      = '0;
            cont1_key[FF_KEY_BIT] = s.key;
            rng    = lcg_next(rng);
            lcd_in = '{hs: s.sync[3], vs: s.sync[2], hblank: s.sync[1],
                       vblank: s.sync[0], pixel: rng[31:8]};
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int step_cycles;
        arst_n         = 1'b0;
        bridge_addr    = '0;
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        bridge_rd      = 1'b0;
        cont1_key      = '0;
        lcd_in         = '0;
        rng            = 32'hef90;
        // register writes and readback
        add_step(OP_WR, ADDR_FF_EN, 32'h0000_0003, 1'b0, VBLANK, 1);
        add_step(OP_RD, ADDR_FF_EN, '0, 1'b0, VBLANK, 2);
        add_step(OP_WR, ADDR_BORDER_EN, 32'h0000_0005, 1'b0, VBLANK, 1);
        add_step(OP_RD, ADDR_BORDER_EN, '0, 1'b0, VBLANK, 2);
        add_step(OP_WR, ADDR_GRAY_EN, 32'hffff_ffff, 1'b0, VBLANK, 1);
        add_step(OP_RD, ADDR_GRAY_EN, '0, 1'b0, VBLANK, 2);
        add_step(OP_RD, 32'h0000_0100, '0, 1'b0, VBLANK, 2);
        add_step(OP_RD, ADDR_RESET, '0, 1'b0, VBLANK, 2);
        // reset pulse, second write restarts it
        add_step(OP_WR, ADDR_RESET, '0, 1'b0, ACTIVE, 10);
        add_step(OP_WR, ADDR_RESET, '0, 1'b0, ACTIVE, 26);
        // tap, tap off, long hold, then disabled
        add_step(OP_IDLE, '0, '0, 1'b1, ACTIVE, 5);
        add_step(OP_IDLE, '0, '0, 1'b0, ACTIVE, 6);
        add_step(OP_IDLE, '0, '0, 1'b1, ACTIVE, 3);
        add_step(OP_IDLE, '0, '0, 1'b0, ACTIVE, 4);
        add_step(OP_IDLE, '0, '0, 1'b1, ACTIVE, 30);
        add_step(OP_IDLE, '0, '0, 1'b0, ACTIVE, 4);
        add_step(OP_WR, ADDR_FF_EN, '0, 1'b0, ACTIVE, 1);
        add_step(OP_RD, ADDR_FF_EN, '0, 1'b0, ACTIVE, 2);
        add_step(OP_IDLE, '0, '0, 1'b1, ACTIVE, 5);
        add_step(OP_IDLE, '0, '0, 1'b0, ACTIVE, 3);
        // sync shaping and pixel colour
        add_step(OP_IDLE, '0, '0, 1'b0, VS_EDGE, 3);
        add_step(OP_IDLE, '0, '0, 1'b0, VBLANK, 3);
        add_step(OP_IDLE, '0, '0, 1'b0, HS_EDGE, 2);
        add_step(OP_IDLE, '0, '0, 1'b0, HBLANK, 8);
        add_step(OP_IDLE, '0, '0, 1'b0, ACTIVE, 10);
        add_step(OP_IDLE, '0, '0, 1'b0, HS_EDGE, 2);
        add_step(OP_IDLE, '0, '0, 1'b0, HBLANK, 2);
        add_step(OP_IDLE, '0, '0, 1'b0, HS_EDGE, 2);
        add_step(OP_IDLE, '0, '0, 1'b0, HBLANK, 8);
        add_step(OP_IDLE, '0, '0, 1'b0, HV_EDGE, 2);
        add_step(OP_IDLE, '0, '0, 1'b0, VBLANK, 8);
        add_step(OP_WR, ADDR_GRAY_EN, '0, 1'b0, ACTIVE, 8);
        add_step(OP_WR, ADDR_BORDER_EN, '0, 1'b0, HBLANK, 4);
        add_step(OP_IDLE, '0, '0, 1'b0, ACTIVE, 4);
        step_cycles = 0;
        foreach (steps[i]) begin
            step_cycles += steps[i].hold;
        end
        timeout_cycles = step_cycles + 10 + 30;
        repeat (10) @(posedge clk_sys);
        #2;
        arst_n = 1'b1;
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        repeat (3) @(posedge clk_sys);
        $display("checks %0d, value errors %0d, assertion failures %0d",
                 check_count, error_count, dut_i.props_i.fail_count);
        if (error_count == 0 && dut_i.props_i.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (timeout_cycles != 0);
        #(timeout_cycles * 40);
        $display("timeout: stimulus still running after %0d cycles", timeout_cycles);
        $display("sim failed");
        $finish;
    end

endmodule

/* verification/frontend_checker.sv */
`timescale 1ns/1ps

module frontend_checker import frontend_regs_pkg::*, video_pkg::*; #(
    parameter int unsigned RESET_HOLD_CYCLES = 20,
    parameter int unsigned FF_TAP_CYCLES     = 16,
    parameter int unsigned HS_DELAY          = 7
) (
    input  logic          clk_sys,
    input  logic          arst_n,
    input  bridge_addr_t  bridge_addr,
    input  logic          bridge_wr,
    input  bridge_data_t  bridge_wr_data,
    input  logic          bridge_rd,
    input  cont_key_t     cont1_key,
    input  lcd_video_t    lcd_in,
    input  bridge_data_t  bridge_rd_data,
    input  logic          core_reset_n,
    input  logic          fast_forward,
    input  scaler_video_t video_out,
    output int            error_count,
    output int            check_count
);

    // only bit 13 set
    localparam logic [23:0] NO_BORDER_PIXEL = 24'h1 << 13;

    typedef enum {FF_IDLE, FF_PRESS, FF_ON, FF_PRESS_ON} ff_model_t;

    int           errors = 0;
    int           checks = 0;
    logic         ff_en;
    logic         border_en;
    logic         gray_en;
    bridge_data_t rd_val;
    int           rst_left;
    ff_model_t    ff_st;
    int           held;
    logic         hs_prev;
    logic         vs_prev;
    int           hs_wait;
    logic         de_m;
    logic         hs_m;
    logic         vs_m;
    logic [23:0]  pix_m;

    assign error_count = errors;
    assign check_count = checks;

    // weights r/4 + r/32, g/2 + g/16, b/16 + b/32
    function automatic logic [7:0] gray_level(input logic [23:0] p);
        int r;
        int g;
        int b;
        r = p[23:16];
        g = p[15:8];
        b = p[7:0];
        return 8'(r / 4 + r / 32 + g / 2 + g / 16 + b / 16 + b / 32);
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // model, checked mid-cycle and then stepped one clock edge
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk_sys) begin
        logic [7:0]  luma;
        logic [23:0] exp_pix;
        logic        key;
        if (!arst_n) begin
            {ff_en, border_en, gray_en} = 3'b000;
            rd_val   = '0;
            rst_left = 0;
            ff_st    = FF_IDLE;
            held     = 0;
            {hs_prev, vs_prev, de_m, hs_m, vs_m} = 5'b0;
            hs_wait  = 0;
            pix_m    = '0;
        end
        luma = gray_level(pix_m);
        if (!de_m) begin
            exp_pix = border_en ? 24'h0 : NO_BORDER_PIXEL;
        end else if (gray_en) begin
            exp_pix = {luma, luma, luma};
        end else begin
            exp_pix = pix_m;
        end
        compare("bridge_rd_data", rd_val, bridge_rd_data);
        compare("core_reset_n", 32'(rst_left == 0), 32'(core_reset_n));
        compare("fast_forward", 32'(ff_st != FF_IDLE), 32'(fast_forward));
        compare("video_out.de", 32'(de_m), 32'(video_out.de));
        compare("video_out.hs", 32'(hs_m), 32'(video_out.hs));
        compare("video_out.vs", 32'(vs_m), 32'(video_out.vs));
        compare("video_out.pixel", 32'(exp_pix), 32'(video_out.pixel));
        if (arst_n) begin
            // readback sees the flags from before this edge
            if (bridge_rd) begin
                rd_val = '0;
                case (bridge_addr)
                    ADDR_FF_EN:     rd_val[0] = ff_en;
                    ADDR_BORDER_EN: rd_val[0] = border_en;
                    ADDR_GRAY_EN:   rd_val[0] = gray_en;
                    default: ;
                endcase
            end
            if (bridge_wr && bridge_addr == ADDR_RESET) begin
                rst_left = RESET_HOLD_CYCLES;
            end else if (rst_left > 0) begin
                rst_left--;
            end
            key = cont1_key[FF_KEY_BIT];
            case (ff_st)
                FF_IDLE: begin
                    if (key) begin
                        ff_st = FF_PRESS;
                        held  = 1;
                    end
                end
                FF_PRESS: begin
                    if (key) begin
                        held = (held < FF_TAP_CYCLES) ? held + 1 : held;
                    end else begin
                        ff_st = (held < FF_TAP_CYCLES) ? FF_ON : FF_IDLE;
                    end
                end
                FF_ON: begin
                    if (key) begin
                        ff_st = FF_PRESS_ON;
                    end
                end
                default: begin
                    if (!key) begin
                        ff_st = FF_IDLE;
                    end
                end
            endcase
            if (!ff_en) begin
                ff_st = FF_IDLE;
            end
            de_m  = !(lcd_in.hblank || lcd_in.vblank);
            pix_m = de_m ? lcd_in.pixel : 24'h0;
            vs_m  = lcd_in.vs && !vs_prev;
            if (lcd_in.hs && !hs_prev) begin
                hs_wait = HS_DELAY;
            end
            hs_m = 1'b0;
            if (hs_wait > 0) begin
                hs_wait--;
                hs_m = (hs_wait == 0);
            end
            hs_prev = lcd_in.hs;
            vs_prev = lcd_in.vs;
            // flag writes land after everything that reads them
            if (bridge_wr) begin
                case (bridge_addr)
                    ADDR_FF_EN:     ff_en     = bridge_wr_data[0];
                    ADDR_BORDER_EN: border_en = bridge_wr_data[0];
                    ADDR_GRAY_EN:   gray_en   = bridge_wr_data[0];
                    default: ;
                endcase
            end
        end
    end

endmodule

/* verification/frontend_properties.sv */
`timescale 1ns/1ps

module frontend_properties import frontend_regs_pkg::*, video_pkg::*; (
    input  logic          clk_sys,
    input  logic          arst_n,
    input  bridge_addr_t  bridge_addr,
    input  logic          bridge_wr,
    input  logic          core_reset_n,
    input  scaler_video_t video_out
);

    int fail_count = 0;

    // reset write pulls the core into reset on the next edge
    reset_write_starts_pulse: assert property (
        @(posedge clk_sys) disable iff (!arst_n)
        (bridge_wr && bridge_addr == ADDR_RESET) |=> !core_reset_n
    ) else begin
        fail_count++;
        $error("core_reset_n stayed high after a reset write");
    end

    vs_single_cycle: assert property (
        @(posedge clk_sys) disable iff (!arst_n)
        video_out.vs |=> !video_out.vs
    ) else begin
        fail_count++;
        $error("vs pulse longer than one cycle");
    end

    hs_single_cycle: assert property (
        @(posedge clk_sys) disable iff (!arst_n)
        video_out.hs |=> !video_out.hs
    ) else begin
        fail_count++;
        $error("hs pulse longer than one cycle");
    end

    // hsync delay exists so the two pulses never meet
    sync_no_overlap: assert property (
        @(posedge clk_sys) disable iff (!arst_n)
        !(video_out.hs && video_out.vs)
    ) else begin
        fail_count++;
        $error("hs and vs high in the same cycle");
    end

endmodule

/* source/gb_frontend.sv */
`timescale 1ns/1ps

module gb_frontend import frontend_regs_pkg::*, video_pkg::*; #(
    parameter int unsigned RESET_HOLD_CYCLES = 1048576,
    parameter int unsigned FF_TAP_CYCLES     = 3200000,
    parameter int unsigned HS_DELAY          = 7
) (
    input  logic          clk_sys,
    input  logic          arst_n,
    input  bridge_addr_t  bridge_addr,
    input  logic          bridge_wr,
    input  bridge_data_t  bridge_wr_data,
    input  logic          bridge_rd,
    input  cont_key_t     cont1_key,
    input  lcd_video_t    lcd_in,
    output bridge_data_t  bridge_rd_data,
    output logic          core_reset_n,
    output logic          fast_forward,
    output scaler_video_t video_out
);

    frontend_settings_t settings;
    scaler_video_t      shaped;

    // host registers, core reset and fast forward
    frontend_control #(
        .RESET_HOLD_CYCLES (RESET_HOLD_CYCLES),
        .FF_TAP_CYCLES     (FF_TAP_CYCLES)
    ) control_i (
        .clk_sys        (clk_sys),
        .arst_n         (arst_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd      (bridge_rd),
        .cont1_key      (cont1_key),
        .bridge_rd_data (bridge_rd_data),
        .settings       (settings),
        .core_reset_n   (core_reset_n),
        .fast_forward   (fast_forward)
    );

    // video path, one register stage then combinational colour
    video_sync_shaper #(
        .HS_DELAY (HS_DELAY)
    ) shaper_i (
        .clk_sys (clk_sys),
        .arst_n  (arst_n),
        .lcd_in  (lcd_in),
        .shaped  (shaped)
    );

    pixel_colour_stage colour_i (
        .shaped    (shaped),
        .border_en (settings.border_en),
        .gray_en   (settings.gray_en),
        .video_out (video_out)
    );

endmodule

/* source/pixel_colour_stage.sv */
`timescale 1ns/1ps

module pixel_colour_stage import video_pkg::*; (
    input  scaler_video_t shaped,
    input  logic          border_en,
    input  logic          gray_en,
    output scaler_video_t video_out
);

    luma_t red;
    luma_t green;
    luma_t blue;
    luma_t luma;

    assign red   = shaped.pixel[23:16];
    assign green = shaped.pixel[15:8];
    assign blue  = shaped.pixel[7:0];

    // approx 0.28 r + 0.56 g + 0.09 b, every term truncated on its own
    assign luma = (red >> 2) + (red >> 5)
                + (green >> 1) + (green >> 4)
                + (blue >> 4) + (blue >> 5);

    ////////////////////////////////////////////////////////////////////////////
    // pixel select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        video_out = shaped;
        if (!shaped.de) begin
            // blanking tells the scaler whether to draw its border
            if (border_en) begin
                video_out.pixel = '0;
            end else begin
                video_out.pixel = BORDER_OFF_RGB;
            end
        end else if (gray_en) begin
            video_out.pixel = {luma, luma, luma};
        end
    end

endmodule

/* source/video_sync_shaper.sv */
`timescale 1ns/1ps

module video_sync_shaper import video_pkg::*; #(
    parameter int unsigned HS_DELAY = 7
) (
    input  logic          clk_sys,
    input  logic          arst_n,
    input  lcd_video_t    lcd_in,
    output scaler_video_t shaped
);

    // counter only has to reach HS_DELAY - 1
    localparam int HS_CNT_W = (HS_DELAY > 1) ? $clog2(HS_DELAY) : 1;

    logic                hs_prev;
    logic                vs_prev;
    logic                hs_rise;
    logic                vs_rise;
    logic                de_in;
    logic [HS_CNT_W-1:0] hs_cnt;
    logic                de_q;
    logic                hs_q;
    logic                vs_q;
    rgb_t                pixel_q;

    assign de_in   = !(lcd_in.hblank || lcd_in.vblank);
    assign hs_rise = lcd_in.hs && !hs_prev;
    assign vs_rise = lcd_in.vs && !vs_prev;

    ////////////////////////////////////////////////////////////////////////////
    // sync pulses
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            hs_prev <= 1'b0;
            vs_prev <= 1'b0;
            hs_cnt  <= '0;
            de_q    <= 1'b0;
            hs_q    <= 1'b0;
            vs_q    <= 1'b0;
        end else begin
            hs_prev <= lcd_in.hs;
            vs_prev <= lcd_in.vs;
            de_q    <= de_in;
            vs_q    <= vs_rise;
            // hsync is pushed back so it never lands on the vsync pulse
            if (hs_rise) begin
                hs_cnt <= HS_CNT_W'(HS_DELAY - 1);
            end else if (hs_cnt != '0) begin
                hs_cnt <= hs_cnt - 1'b1;
            end
            hs_q <= hs_rise ? (HS_DELAY == 1) : (hs_cnt == HS_CNT_W'(1));
        end
    end

    // pixel zeroed outside the active area
    always_ff @(posedge clk_sys) begin
        pixel_q <= de_in ? lcd_in.pixel : '0;
    end

    assign shaped = '{de: de_q, hs: hs_q, vs: vs_q, pixel: pixel_q};

endmodule

/* source/frontend_control.sv */
`timescale 1ns/1ps

module frontend_control import frontend_regs_pkg::*; #(
    parameter int unsigned RESET_HOLD_CYCLES = 1048576,
    parameter int unsigned FF_TAP_CYCLES     = 3200000
) (
    input  logic               clk_sys,
    input  logic               arst_n,
    input  bridge_addr_t       bridge_addr,
    input  logic               bridge_wr,
    input  bridge_data_t       bridge_wr_data,
    input  logic               bridge_rd,
    input  cont_key_t          cont1_key,
    output bridge_data_t       bridge_rd_data,
    output frontend_settings_t settings,
    output logic               core_reset_n,
    output logic               fast_forward
);

    localparam int RST_CNT_W = $clog2(RESET_HOLD_CYCLES + 1);
    localparam int TAP_CNT_W = $clog2(FF_TAP_CYCLES + 1);

    typedef enum logic [1:0] {
        OFF,
        HELD_NEW,
        LATCHED,
        HELD_LATCHED
    } ff_state_t;

    logic [RST_CNT_W-1:0] rst_cnt;
    logic [TAP_CNT_W-1:0] hold_cnt;
    ff_state_t            ff_state;
    ff_state_t            ff_state_next;
    logic                 ff_key;
    bridge_data_t         rd_mux;

    ////////////////////////////////////////////////////////////////////////////
    // register bank
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            settings <= '0;
        end else if (bridge_wr) begin
            case (bridge_addr)
                ADDR_FF_EN:     settings.ff_en     <= bridge_wr_data[0];
                ADDR_BORDER_EN: settings.border_en <= bridge_wr_data[0];
                ADDR_GRAY_EN:   settings.gray_en   <= bridge_wr_data[0];
                default: ;
            endcase
        end
    end

    // reset register and unmapped addresses read as zero
    always_comb begin
        rd_mux = '0;
        case (bridge_addr)
            ADDR_FF_EN:     rd_mux[0] = settings.ff_en;
            ADDR_BORDER_EN: rd_mux[0] = settings.border_en;
            ADDR_GRAY_EN:   rd_mux[0] = settings.gray_en;
            default: ;
        endcase
    end

    // read data holds until the next strobe
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            bridge_rd_data <= '0;
        end else if (bridge_rd) begin
            bridge_rd_data <= rd_mux;
        end
    end

    // core reset pulse, a repeat write reloads the count
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            rst_cnt <= '0;
        end else if (bridge_wr && bridge_addr == ADDR_RESET) begin
            rst_cnt <= RST_CNT_W'(RESET_HOLD_CYCLES);
        end else if (rst_cnt != '0) begin
            rst_cnt <= rst_cnt - 1'b1;
        end
    end

    assign core_reset_n = (rst_cnt == '0);

    ////////////////////////////////////////////////////////////////////////////
    // fast forward, hold or tap
    ////////////////////////////////////////////////////////////////////////////

    assign ff_key = cont1_key[FF_KEY_BIT];

    always_comb begin
        ff_state_next = ff_state;
        case (ff_state)
            OFF: begin
                if (ff_key) begin
                    ff_state_next = HELD_NEW;
                end
            end
            HELD_NEW: begin
                // short press latches, long press was only a hold
                if (!ff_key) begin
                    ff_state_next = (hold_cnt < TAP_CNT_W'(FF_TAP_CYCLES)) ? LATCHED : OFF;
                end
            end
            LATCHED: begin
                if (ff_key) begin
                    ff_state_next = HELD_LATCHED;
                end
            end
            HELD_LATCHED: begin
                if (!ff_key) begin
                    ff_state_next = OFF;
                end
            end
            default: ff_state_next = OFF;
        endcase
        if (!settings.ff_en) begin
            ff_state_next = OFF;
        end
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            ff_state     <= OFF;
            hold_cnt     <= '0;
            fast_forward <= 1'b0;
        end else begin
            ff_state     <= ff_state_next;
            fast_forward <= (ff_state_next != OFF);
            // the press that leaves OFF is the first held cycle
            if (ff_state == OFF) begin
                hold_cnt <= TAP_CNT_W'(1);
            end else if (ff_state == HELD_NEW && hold_cnt != TAP_CNT_W'(FF_TAP_CYCLES)) begin
                hold_cnt <= hold_cnt + 1'b1;
            end
        end
    end

endmodule

/* source/video_pkg.sv */
package video_pkg;

    // red [23:16], green [15:8], blue [7:0]
    typedef logic [23:0] rgb_t;
    typedef logic [7:0]  luma_t;

    // raw timing and pixel from the LCD
    typedef struct packed {
        logic hs;
        logic vs;
        logic hblank;
        logic vblank;
        rgb_t pixel;
    } lcd_video_t;

    // format expected by the scaler
    typedef struct packed {
        logic de;
        logic hs;
        logic vs;
        rgb_t pixel;
    } scaler_video_t;

    // blanking marker the scaler reads as "no border"
    localparam rgb_t BORDER_OFF_RGB = 24'h00_2000;

endpackage

/* source/frontend_regs_pkg.sv */
package frontend_regs_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bridge bus words
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0] bridge_addr_t;
    typedef logic [31:0] bridge_data_t;

    // controller key bitmap, one bit per button
    typedef logic [31:0] cont_key_t;

    // trig_r1 drives fast forward
    localparam int FF_KEY_BIT = 9;

    ////////////////////////////////////////////////////////////////////////////
    // register map
    ////////////////////////////////////////////////////////////////////////////

    // write-only, starts the core reset pulse
    localparam bridge_addr_t ADDR_RESET     = 32'h0000_0050;

    // single-bit settings, data bit 0
    localparam bridge_addr_t ADDR_FF_EN     = 32'h0000_020C;
    localparam bridge_addr_t ADDR_BORDER_EN = 32'h0000_0218;
    localparam bridge_addr_t ADDR_GRAY_EN   = 32'h0000_021C;

    ////////////////////////////////////////////////////////////////////////////
    // settings seen by the rest of the front end
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic ff_en;
        logic border_en;
        logic gray_en;
    } frontend_settings_t;

endpackage
